// ==== icache_sub.f ====
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_fill.sv
rtl/icache_regs.sv
rtl/icache_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_model.sv
dv/icache_tb.sv

// ==== dv/icache_testdata.txt ====
// columns: opcode_address_value, hex. 01 read that may wait, 02 read that must hit,
// 03 register write, 04 register check, 05 bus log (first address, word count),
// 06 whole line read as hits, 00 end.
04_00000001_00000000 // counters and enable after reset.
04_00000002_00000000
04_00000000_00000001
04_00000003_1cac0116
01_00001044_5a5a1044 // cold miss on line 1.
05_00001040_00000010
02_0000107c_5a5a107c
06_00001040_00000000
05_00000000_00000000
01_00003048_5a5a3048 // same line, other tag.
05_00003040_00000010
01_00001050_5a5a1050
05_00001040_00000010
01_00003040_5a5a3040
05_00003040_00000010
02_0000307c_5a5a307c
04_00000001_00000016
04_00000002_00000004
03_00000000_00000003 // invalidate all, stay enabled.
04_00000000_00000001
01_00003044_5a5a3044
05_00003040_00000010
03_00000000_00000000 // uncached mode.
04_00000000_00000000
01_00003044_5a5a3044
05_00003044_00000001
01_00002008_5a5a2008
05_00002008_00000001
04_00000002_00000005
04_00000001_00000017
03_00000000_00000001
02_00003048_5a5a3048
01_00002008_5a5a2008
05_00002000_00000010
02_0000203c_5a5a203c
04_00000001_0000001a
04_00000002_00000006
04_00000003_1cac0116
00_00000000_00000000

// ==== dv/icache_tb.sv ====
// Testbench top for the instruction cache subsystem. Runs the command records of
// the test data file against the DUT, with a behavioral bus memory behind it.

`timescale 1ns/1ps

module icache_tb;

	localparam int MAX_CMDS       = 64;
	localparam int CYCLES_PER_CMD = 60;

	logic                  clk;
	logic                  arst_n;
	icache_pkg::addr_t     rd_addr;
	logic                  rd_req;
	logic                  rd_wait;
	icache_pkg::word_t     rd_data;
	logic                  bus_req;
	logic                  bus_ack;
	icache_pkg::addr_t     bus_addr;
	logic                  bus_rd;
	icache_pkg::word_t     bus_rdata;
	logic                  bus_ready;
	icache_pkg::reg_addr_t reg_addr;
	logic                  reg_wr;
	icache_pkg::word_t     reg_wdata;
	icache_pkg::word_t     reg_rdata;

	logic [71:0] cmd_mem [MAX_CMDS]; // opcode, address, value.
	int          num_cmds;
	int          log_seen;
	int          cycle_cnt = 0;
	int          cycle_limit;
	int          i;

	tb_clk_gen   i_clk_gen (.*);
	tb_mem_model i_mem (.*);
	icache_top   i_dut (.*);

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// One core read. A read that must hit is checked for rd_wait and bus_req in the
	// request cycle, and a waiting read must keep its bus request up.
	task automatic core_read(input icache_pkg::addr_t addr, input icache_pkg::word_t exp,
		input logic must_hit);
		@(negedge clk);
		rd_addr <= addr;
		rd_req  <= 1'b1;
		@(posedge clk);
		if (must_hit) begin
			check_value("rd_wait", rd_wait, 32'd0);
			check_value("bus_req", bus_req, 32'd0);
		end
		while (rd_wait) begin
			check_value("bus_req", bus_req, 32'd1);
			@(posedge clk);
		end
		check_value("rd_data", rd_data, exp);
		@(negedge clk);
		rd_req <= 1'b0;
	endtask

	task automatic reg_write(input icache_pkg::reg_addr_t addr, input icache_pkg::word_t data);
		@(negedge clk);
		reg_addr  <= addr;
		reg_wdata <= data;
		reg_wr    <= 1'b1;
		@(negedge clk);
		reg_wr <= 1'b0;
	endtask

	task automatic reg_check(input icache_pkg::reg_addr_t addr, input icache_pkg::word_t exp);
		@(negedge clk);
		reg_addr <= addr;
		@(posedge clk);
		check_value("reg_rdata", reg_rdata, exp);
	endtask

	// compares the bus words taken since the last check against an ordered run.
	task automatic bus_log_check(input icache_pkg::addr_t first, input int count);
		int k;
		@(negedge clk);
		check_value("bus_req", bus_req, 32'd0); // no request is pending here.
		check_value("bus_rd", bus_rd, 32'd0);
		check_value("bus word count", i_mem.log_cnt - log_seen, count);
		for (k = 0; k < count; k++) begin
			check_value("bus_addr", i_mem.addr_log[log_seen + k], first + 4 * k);
		end
		log_seen = i_mem.log_cnt;
	endtask

	task automatic run_command(input logic [71:0] cmd);
		logic [7:0]        op;
		icache_pkg::addr_t addr;
		icache_pkg::word_t value;
		int                k;
		op    = cmd[71:64];
		addr  = cmd[63:32];
		value = cmd[31:0];
		case (op)
			8'h01: core_read(addr, value, 1'b0);
			8'h02: core_read(addr, value, 1'b1);
			8'h03: reg_write(addr[1:0], value);
			8'h04: reg_check(addr[1:0], value);
			8'h05: bus_log_check(addr, value);
			8'h06: begin
				// every word of the line must hit and hold what the memory's data rule gives.
				for (k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
					core_read(addr + 4 * k, (addr + 4 * k) ^ 32'h5a5a_0000, 1'b1);
				end
			end
			default: begin
				$display("Error: unknown opcode %h in the test data", op);
				$display("Result: FAILED");
				$fatal(1, "bad test data");
			end
		endcase
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Error: the run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rd_addr   = '0;
		rd_req    = 1'b0;
		reg_addr  = '0;
		reg_wr    = 1'b0;
		reg_wdata = '0;
		log_seen  = 0;
		$readmemh("dv/icache_testdata.txt", cmd_mem);
		num_cmds = 0;
		while ((num_cmds < MAX_CMDS) && (cmd_mem[num_cmds][71:64] != 8'h00)) begin
			num_cmds++;
		end
		cycle_limit = num_cmds * CYCLES_PER_CMD;
		if (num_cmds == 0) begin
			$display("Error: the test data file holds no commands");
			$display("Result: FAILED");
			$fatal(1, "no stimulus");
		end
		@(posedge arst_n);
		for (i = 0; i < num_cmds; i++) begin
			run_command(cmd_mem[i]);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== dv/tb_mem_model.sv ====
// Behavioral read memory behind the cache bus. Grants one cycle after a request,
// answers each word after a pseudo-random gap and logs every word address taken.

`timescale 1ns/1ps

module tb_mem_model (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              bus_req,
	output logic              bus_ack,
	input  icache_pkg::addr_t bus_addr,
	input  logic              bus_rd,
	output icache_pkg::word_t bus_rdata,
	output logic              bus_ready
);

	localparam int LOG_DEPTH = 256;

	icache_pkg::addr_t addr_log [LOG_DEPTH];
	int                log_cnt;
	logic [31:0]       lcg_state;
	logic [1:0]        gap;
	logic              taken;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// every word holds its own address with a fixed pattern folded in.
	assign bus_rdata = bus_addr ^ 32'h5a5a_0000;
	assign bus_ready = bus_rd && (gap == 2'd0);

	// words are logged at the edge where the DUT takes them.
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			log_cnt <= 0;
			taken   <= 1'b0;
		end else begin
			taken <= bus_rd && bus_ready;
			if (bus_rd && bus_ready) begin
				if (log_cnt < LOG_DEPTH) begin
					addr_log[log_cnt] <= bus_addr;
				end
				log_cnt <= log_cnt + 1;
			end
		end
	end

	always @(negedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus_ack   <= 1'b0;
			gap       <= 2'd0;
			lcg_state <= 32'hbe75_83e7;
		end else begin
			bus_ack <= bus_req; // grant follows the request by one cycle.
			if (taken) begin
				lcg_state <= lcg_next(lcg_state);
				gap       <= lcg_state[31:30]; // idle cycles before the next word.
			end else if (bus_rd && (gap != 2'd0)) begin
				gap <= gap - 2'd1;
			end
		end
	end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset. 40 ns clock, reset held low for the first five cycles
// and released on a falling edge.

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n <= 1'b1;
	end

endmodule

// ==== rtl/icache_top.sv ====
// Instruction fetch subsystem top. Connects the line storage, the miss sequencer
// and the register block to the core, read bus and debug register ports.

`timescale 1ns/1ps

module icache_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  icache_pkg::addr_t     rd_addr,
	input  logic                  rd_req,
	output logic                  rd_wait,
	output icache_pkg::word_t     rd_data,
	output logic                  bus_req,
	input  logic                  bus_ack,
	output icache_pkg::addr_t     bus_addr,
	output logic                  bus_rd,
	input  icache_pkg::word_t     bus_rdata,
	input  logic                  bus_ready,
	input  icache_pkg::reg_addr_t reg_addr,
	input  logic                  reg_wr,
	input  icache_pkg::word_t     reg_wdata,
	output icache_pkg::word_t     reg_rdata
);

	logic                  hit;
	logic                  cache_en;
	logic                  inval_pulse;
	logic                  fill_we;
	icache_pkg::word_idx_t fill_word;
	icache_pkg::word_t     fill_data;
	logic                  line_done;
	logic                  byp_valid;
	icache_pkg::word_t     byp_data;

	icache_array i_array (
		.clk         (clk),
		.arst_n      (arst_n),
		.rd_addr     (rd_addr),
		.rd_req      (rd_req),
		.cache_en    (cache_en),
		.inval_pulse (inval_pulse),
		.fill_we     (fill_we),
		.fill_word   (fill_word),
		.fill_data   (fill_data),
		.line_done   (line_done),
		.byp_valid   (byp_valid),
		.byp_data    (byp_data),
		.hit         (hit),
		.rd_wait     (rd_wait),
		.rd_data     (rd_data)
	);

	icache_fill i_fill (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr   (rd_addr),
		.rd_req    (rd_req),
		.hit       (hit),
		.cache_en  (cache_en),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready),
		.bus_req   (bus_req),
		.bus_addr  (bus_addr),
		.bus_rd    (bus_rd),
		.fill_we   (fill_we),
		.fill_word (fill_word),
		.fill_data (fill_data),
		.line_done (line_done),
		.byp_valid (byp_valid),
		.byp_data  (byp_data)
	);

	icache_regs i_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.reg_addr    (reg_addr),
		.reg_wr      (reg_wr),
		.reg_wdata   (reg_wdata),
		.rd_req      (rd_req),
		.hit         (hit),
		.line_done   (line_done),
		.reg_rdata   (reg_rdata),
		.cache_en    (cache_en),
		.inval_pulse (inval_pulse)
	);

endmodule

// ==== rtl/icache_regs.sv ====
// Control and status registers beside the cache: enable, invalidate-all and the
// saturating hit and fill counters, readable through the debug register port.

`timescale 1ns/1ps

module icache_regs (
	input  logic                  clk,
	input  logic                  arst_n,
	input  icache_pkg::reg_addr_t reg_addr,
	input  logic                  reg_wr,
	input  icache_pkg::word_t     reg_wdata,
	input  logic                  rd_req,
	input  logic                  hit,
	input  logic                  line_done,
	output icache_pkg::word_t     reg_rdata,
	output logic                  cache_en,
	output logic                  inval_pulse
);

	icache_pkg::count_t hit_cnt;
	icache_pkg::count_t fill_cnt;

	logic ctrl_wr;

	assign ctrl_wr = reg_wr && (reg_addr == icache_pkg::REG_CTRL);

	// Bit 1 of a control write clears every line at the same edge that takes the
	// write. It is never stored, so it reads back as zero.
	assign inval_pulse = ctrl_wr && reg_wdata[1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cache_en <= 1'b1; // the cache comes out of reset enabled.
			hit_cnt  <= '0;
			fill_cnt <= '0;
		end else begin
			if (ctrl_wr) begin
				cache_en <= reg_wdata[0];
			end
			if (rd_req && hit && (hit_cnt != '1)) begin
				hit_cnt <= hit_cnt + 1'b1; // counts every cycle a request hits.
			end
			if (line_done && (fill_cnt != '1)) begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		case (reg_addr)
			icache_pkg::REG_CTRL:  reg_rdata = {31'b0, cache_en};
			icache_pkg::REG_HITS:  reg_rdata = {16'b0, hit_cnt};
			icache_pkg::REG_FILLS: reg_rdata = {16'b0, fill_cnt};
			default:               reg_rdata = icache_pkg::ICACHE_ID;
		endcase
	end

endmodule

// ==== rtl/icache_fill.sv ====
// Miss sequencer. Fetches a whole line in word order over the read bus, or a single
// word when the cache is disabled, and hands the words to the line storage.

`timescale 1ns/1ps

module icache_fill (
	input  logic                  clk,
	input  logic                  arst_n,
	input  icache_pkg::addr_t     rd_addr,
	input  logic                  rd_req,
	input  logic                  hit,
	input  logic                  cache_en,
	input  logic                  bus_ack,
	input  icache_pkg::word_t     bus_rdata,
	input  logic                  bus_ready,
	output logic                  bus_req,
	output icache_pkg::addr_t     bus_addr,
	output logic                  bus_rd,
	output logic                  fill_we,
	output icache_pkg::word_idx_t fill_word,
	output icache_pkg::word_t     fill_data,
	output logic                  line_done,
	output logic                  byp_valid,
	output icache_pkg::word_t     byp_data
);

	icache_pkg::fill_state_t state;
	icache_pkg::fill_state_t state_nxt;
	icache_pkg::word_idx_t   word_cnt;

	logic miss;
	logic active;
	logic xfer;

	assign miss   = rd_req && !hit;
	assign active = (state == icache_pkg::line_fill) || (state == icache_pkg::bypass_read);
	assign xfer   = active && bus_ack && bus_ready; // one word arrives this cycle.

	// bus_req rises in the cycle of the miss itself and stays up until the last word.
	assign bus_req = ((state == icache_pkg::idle) && miss) || active;
	assign bus_rd  = active && bus_ack;

	always_comb begin
		bus_addr = '0;
		if (active && bus_ack) begin
			if (state == icache_pkg::line_fill) begin
				bus_addr = {rd_addr[31:6], word_cnt, 2'b00};
			end else begin
				bus_addr = {rd_addr[31:2], 2'b00};
			end
		end
	end

	assign fill_we   = xfer && (state == icache_pkg::line_fill);
	assign fill_word = word_cnt;
	assign fill_data = bus_rdata;
	assign line_done = fill_we &&
		(word_cnt == icache_pkg::word_idx_t'(icache_pkg::WORDS_PER_LINE - 1));
	assign byp_valid = (state == icache_pkg::bypass_done);

	always_comb begin
		state_nxt = state;
		case (state)
			icache_pkg::idle: begin
				if (miss) begin
					state_nxt = cache_en ? icache_pkg::line_fill : icache_pkg::bypass_read;
				end
			end
			icache_pkg::line_fill:   if (line_done) state_nxt = icache_pkg::idle;
			icache_pkg::bypass_read: if (xfer) state_nxt = icache_pkg::bypass_done;
			default:                 state_nxt = icache_pkg::idle; // word shown for one cycle.
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= icache_pkg::idle;
			word_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == icache_pkg::idle) begin
				word_cnt <= '0;
			end else if (fill_we) begin
				word_cnt <= word_cnt + 1'b1; // wraps back to zero after the last word.
			end
		end
	end

	// the uncached word is held here for the cycle after it arrives.
	always_ff @(posedge clk) begin
		if (xfer && (state == icache_pkg::bypass_read)) begin
			byp_data <= bus_rdata;
		end
	end

endmodule

// ==== rtl/icache_array.sv ====
// Direct-mapped line storage with valid bits and tags. Reads and hit detection are
// combinational; fill words and line completion are written at the clock edge.

`timescale 1ns/1ps

module icache_array (
	input  logic                  clk,
	input  logic                  arst_n,
	input  icache_pkg::addr_t     rd_addr,
	input  logic                  rd_req,
	input  logic                  cache_en,
	input  logic                  inval_pulse,
	input  logic                  fill_we,
	input  icache_pkg::word_idx_t fill_word,
	input  icache_pkg::word_t     fill_data,
	input  logic                  line_done,
	input  logic                  byp_valid,
	input  icache_pkg::word_t     byp_data,
	output logic                  hit,
	output logic                  rd_wait,
	output icache_pkg::word_t     rd_data
);

	logic [icache_pkg::NUM_LINES-1:0] valid;

	icache_pkg::tag_t  tag_mem  [icache_pkg::NUM_LINES];
	icache_pkg::word_t data_mem [icache_pkg::NUM_LINES][icache_pkg::WORDS_PER_LINE];

	icache_pkg::tag_t      rd_tag;
	icache_pkg::line_idx_t rd_line;
	icache_pkg::word_idx_t rd_word;

	// split the request address into its three fields.
	assign rd_tag  = rd_addr[31:10];
	assign rd_line = rd_addr[9:6];
	assign rd_word = rd_addr[5:2];

	// A disabled cache never reports a hit, so every request goes to the fill
	// engine and becomes an uncached read there.
	assign hit = cache_en && valid[rd_line] && (tag_mem[rd_line] == rd_tag);

	// the core waits until it has either a hit or a bypass word.
	assign rd_wait = rd_req && !hit && !byp_valid;

	// the bypass word takes precedence over the stored line.
	assign rd_data = byp_valid ? byp_data : data_mem[rd_line][rd_word];

	// Valid bits. The line being filled is the one that rd_addr points at, since
	// the core holds its address steady for the whole miss.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (inval_pulse) begin
			valid <= '0; // invalidate-all wins over a completing fill.
		end else if (line_done) begin
			valid[rd_line] <= 1'b1;
		end
	end

	// tag store, written together with the last word of a line.
	always_ff @(posedge clk) begin
		if (line_done) begin
			tag_mem[rd_line] <= rd_tag;
		end
	end

	// data store, one word per fill strobe.
	always_ff @(posedge clk) begin
		if (fill_we) begin
			data_mem[rd_line][fill_word] <= fill_data;
		end
	end

endmodule

// ==== rtl/icache_pkg.sv ====
// Shared widths, address field types, fill FSM states and register map for the
// instruction cache subsystem. Every other file refers to it by scoped names.

package icache_pkg;

	localparam int TAG_W  = 22; // address bits 31 down to 10.
	localparam int LINE_W = 4;  // address bits 9 down to 6.
	localparam int WORD_W = 4;  // address bits 5 down to 2.

	localparam int NUM_LINES      = 16;
	localparam int WORDS_PER_LINE = 16;

	typedef logic [31:0]         addr_t;
	typedef logic [31:0]         word_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [LINE_W-1:0]   line_idx_t;
	typedef logic [WORD_W-1:0]   word_idx_t;
	typedef logic [15:0]         count_t;
	typedef logic [1:0]          reg_addr_t;

	// states of the miss and uncached read sequencer.
	typedef enum logic [1:0] {
		idle,
		line_fill,
		bypass_read,
		bypass_done
	} fill_state_t;

	localparam reg_addr_t REG_CTRL  = 2'd0; // bit 0 enable, bit 1 invalidate on write.
	localparam reg_addr_t REG_HITS  = 2'd1; // read-only hit counter.
	localparam reg_addr_t REG_FILLS = 2'd2; // read-only line fill counter.
	localparam reg_addr_t REG_ID    = 2'd3; // read-only identifier.

	localparam word_t ICACHE_ID = 32'h1cac_0116;

endpackage
